//--- hdl/alu.sv
`default_nettype none

module alu (
	input sparc_pkg::alu_op_e op,
	input sparc_pkg::word_t a,
	input sparc_pkg::word_t b,
	output sparc_pkg::word_t y
);
	import sparc_pkg::*;

	logic [4:0] shamt;

	// Shift count from low bits of b
	assign shamt = b[4:0];

	always_comb begin
		case (op)
			alu_add: begin
				y = a + b;
			end
			alu_sub: begin
				y = a - b;
			end
			alu_and: begin
				y = a & b;
			end
			alu_or: begin
				y = a | b;
			end
			alu_xor: begin
				y = a ^ b;
			end
			// Inverted second operand
			alu_andn: begin
				y = a & ~b;
			end
			alu_orn: begin
				y = a | ~b;
			end
			alu_sll: begin
				y = a << shamt;
			end
			alu_srl: begin
				y = a >> shamt;
			end
			alu_sra: begin
				// Sign bit fills from the left
				y = word_t'($signed(a) >>> shamt);
			end
			default: begin
				y = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/control_unit.sv
`default_nettype none

module control_unit (
	input logic clk,
	input logic RESET,
	input logic start,
	input sparc_pkg::decoded_t dec,
	output logic busy,
	output logic done,
	output logic illegal,
	output sparc_pkg::reg_idx_t rs_a,
	output sparc_pkg::reg_idx_t rs_b,
	output sparc_pkg::reg_idx_t rd,
	output logic rf_we,
	output logic wb_sel,
	output sparc_pkg::alu_op_e alu_op,
	output logic b_imm,
	output sparc_pkg::word_t imm,
	input sparc_pkg::word_t alu_y,
	mem_bus_if.ctrl mem
);
	import sparc_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_exec,
		st_mem_addr,
		st_mem_wait,
		st_writeback
	} state_e;

	state_e state;
	state_e state_nx;
	logic is_mem;
	logic is_store;
	word_t st_data;

	// Illegal memory op3 runs the short path
	assign is_mem = dec.legal && dec.family == fam_mem;

	always_comb begin
		is_store = 1'b0;
		if (is_mem) begin
			case (dec.op3)
				mem_st, mem_stb, mem_sth: is_store = 1'b1;
				default: is_store = 1'b0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (RESET) begin
			state <= st_idle;
		end else begin
			state <= state_nx;
		end
	end

	always_comb begin
		state_nx = state;
		case (state)
			st_idle: begin
				if (start) begin
					state_nx = is_mem ? st_mem_addr : st_exec;
				end
			end
			st_exec: state_nx = st_idle;
			st_mem_addr: state_nx = st_mem_wait;
			st_mem_wait: begin
				// Stretched by mfc on the port side
				if (mem.complete) begin
					state_nx = st_writeback;
				end
			end
			st_writeback: state_nx = st_idle;
			default: state_nx = st_idle;
		endcase
	end

	// Operand routing
	always_comb begin
		rs_a   = dec.rs1;
		rs_b   = dec.rs2;
		b_imm  = dec.use_imm;
		alu_op = alu_op_e'(dec.op3);
		if (state == st_idle && is_store) begin
			// r0 | rd passes store data through the ALU
			rs_a   = '0;
			rs_b   = dec.rd;
			b_imm  = 1'b0;
			alu_op = alu_or;
		end else if (state == st_mem_addr) begin
			// Effective address rs1 + rs2/simm13
			alu_op = alu_add;
		end
	end

	// Store data held for the request cycle
	always_ff @(posedge clk) begin
		if (state == st_idle && start && is_store) begin
			st_data <= alu_y;
		end
	end

	assign imm = dec.imm;
	assign rd  = dec.rd;

	// Arith writes in exec, loads in writeback from MDR
	assign rf_we = (state == st_exec && dec.legal && dec.family == fam_arith) ||
		(state == st_writeback && !is_store);
	assign wb_sel = state == st_writeback;

	assign done    = state == st_exec || state == st_writeback;
	assign illegal = state == st_exec && !dec.legal;
	assign busy    = start || state != st_idle;

	// One cycle request from the address state
	assign mem.req_read  = state == st_mem_addr && !is_store;
	assign mem.req_write = state == st_mem_addr && is_store;
	assign mem.addr      = alu_y;
	assign mem.wdata     = st_data;
	assign mem.signed_load = dec.op3 == mem_ldsb || dec.op3 == mem_ldsh;

	always_comb begin
		case (dec.op3)
			mem_ldub, mem_ldsb, mem_stb: mem.size = size_byte;
			mem_lduh, mem_ldsh, mem_sth: mem.size = size_half;
			default: mem.size = size_word;
		endcase
	end

	// Nothing new until the port reports completion
	a_no_overlap: assert property (@(posedge clk) disable iff (RESET)
		(mem.req_read || mem.req_write) |=>
		(!(mem.req_read || mem.req_write) until mem.complete));

	a_word_align: assert property (@(posedge clk) disable iff (RESET)
		((mem.req_read || mem.req_write) && mem.size == size_word) |->
		mem.addr[1:0] == 2'b00);

	a_half_align: assert property (@(posedge clk) disable iff (RESET)
		((mem.req_read || mem.req_write) && mem.size == size_half) |->
		mem.addr[0] == 1'b0);

	a_done_pulse: assert property (@(posedge clk) disable iff (RESET)
		done |=> !done);

endmodule

`default_nettype wire

//--- hdl/instr_decoder.sv
`default_nettype none

module instr_decoder (
	input logic clk,
	input logic RESET,
	input sparc_pkg::word_t ir,
	input logic ir_valid,
	input logic busy,
	output logic start,
	output sparc_pkg::decoded_t dec
);
	import sparc_pkg::*;

	word_t ir_q;
	logic accept;

	// Strobe only counts while the core is idle
	assign accept = ir_valid && !busy;

	always_ff @(posedge clk) begin
		if (RESET) begin
			start <= 1'b0;
		end else begin
			start <= accept;
		end
	end

	// Instruction register
	always_ff @(posedge clk) begin
		if (accept) begin
			ir_q <= ir;
		end
	end

	always_comb begin
		dec.family  = family_e'(ir_q[31:30]);
		dec.rd      = ir_q[29:25];
		dec.op3     = ir_q[24:19];
		dec.rs1     = ir_q[18:14];
		dec.use_imm = ir_q[13];
		dec.rs2     = ir_q[4:0];
		// simm13 sign extended to a word
		dec.imm     = {{19{ir_q[12]}}, ir_q[12:0]};
		dec.legal   = 1'b1;
		// Branch and call always pass as no-ops
		if (ir_q[31:30] == fam_arith) begin
			case (ir_q[24:19])
				alu_add, alu_and, alu_or, alu_xor, alu_sub,
				alu_andn, alu_orn, alu_sll, alu_srl, alu_sra: dec.legal = 1'b1;
				default: dec.legal = 1'b0;
			endcase
		end else if (ir_q[31:30] == fam_mem) begin
			case (ir_q[24:19])
				mem_ld, mem_ldub, mem_lduh, mem_ldsb, mem_ldsh,
				mem_st, mem_stb, mem_sth: dec.legal = 1'b1;
				default: dec.legal = 1'b0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/mem_bus_if.sv
`default_nettype none

interface mem_bus_if;
	import sparc_pkg::*;

	// Request side, one cycle pulse
	logic req_read;
	logic req_write;
	word_t addr;
	word_t wdata;
	mem_size_e size;
	logic signed_load;

	// Completion side
	word_t rdata;
	logic complete;

	modport ctrl (
		output req_read, req_write, addr, wdata, size, signed_load,
		input rdata, complete
	);

	modport port (
		input req_read, req_write, addr, wdata, size, signed_load,
		output rdata, complete
	);

endinterface

`default_nettype wire

//--- hdl/mem_port.sv
`default_nettype none

module mem_port (
	input logic clk,
	input logic RESET,
	mem_bus_if.port bus,
	output sparc_pkg::word_t mem_addr,
	output sparc_pkg::word_t mem_wdata,
	output sparc_pkg::mem_size_e mem_size,
	output logic mem_read,
	output logic mem_write,
	input sparc_pkg::word_t mem_rdata,
	input logic mfc
);
	import sparc_pkg::*;

	word_t mar;
	word_t mdr;
	mem_size_e size_q;
	logic sign_q;
	logic complete_q;
	word_t ext_data;

	// Strobes and completion
	always_ff @(posedge clk) begin
		if (RESET) begin
			mem_read   <= 1'b0;
			mem_write  <= 1'b0;
			complete_q <= 1'b0;
		end else begin
			complete_q <= 1'b0;
			if (bus.req_read || bus.req_write) begin
				mem_read  <= bus.req_read;
				mem_write <= bus.req_write;
			end else if ((mem_read || mem_write) && mfc) begin
				mem_read   <= 1'b0;
				mem_write  <= 1'b0;
				complete_q <= 1'b1;
			end
		end
	end

	// MAR and MDR capture
	always_ff @(posedge clk) begin
		if (bus.req_read || bus.req_write) begin
			mar    <= bus.addr;
			mdr    <= bus.wdata;
			size_q <= bus.size;
			sign_q <= bus.signed_load;
		end else if (mem_read && mfc) begin
			mdr <= ext_data;
		end
	end

	// Memory returns data right aligned, extend by size
	always_comb begin
		case (size_q)
			size_byte: ext_data = {{24{sign_q & mem_rdata[7]}}, mem_rdata[7:0]};
			size_half: ext_data = {{16{sign_q & mem_rdata[15]}}, mem_rdata[15:0]};
			default: ext_data = mem_rdata;
		endcase
	end

	assign mem_addr     = mar;
	assign mem_wdata    = mdr;
	assign mem_size     = size_q;
	assign bus.rdata    = mdr;
	assign bus.complete = complete_q;

	a_one_strobe: assert property (@(posedge clk) disable iff (RESET)
		!(mem_read && mem_write));

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
`default_nettype none

module reg_file (
	input logic clk,
	input logic RESET,
	input sparc_pkg::reg_idx_t ra,
	input sparc_pkg::reg_idx_t rb,
	output sparc_pkg::word_t a,
	output sparc_pkg::word_t b,
	input sparc_pkg::reg_idx_t wa,
	input logic we,
	input sparc_pkg::word_t wd
);
	import sparc_pkg::*;

	word_t regs [32];

	// Synchronous write, r0 never written
	always_ff @(posedge clk) begin
		if (RESET) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// Async read ports
	assign a = (ra == '0) ? '0 : regs[ra];
	assign b = (rb == '0) ? '0 : regs[rb];

endmodule

`default_nettype wire

//--- hdl/sparc_core.sv
`default_nettype none

module sparc_core (
	input logic clk,
	input logic RESET,
	input logic [31:0] ir,
	input logic ir_valid,
	output logic busy,
	output logic done,
	output logic illegal,
	output logic [31:0] mem_addr,
	output logic [31:0] mem_wdata,
	output logic [1:0] mem_size,
	output logic mem_read,
	output logic mem_write,
	input logic [31:0] mem_rdata,
	input logic mfc
);
	import sparc_pkg::*;

	decoded_t dec;
	logic start;
	reg_idx_t rs_a;
	reg_idx_t rs_b;
	reg_idx_t rd;
	logic rf_we;
	logic wb_sel;
	alu_op_e alu_op;
	logic b_imm;
	word_t imm;
	word_t rf_a;
	word_t rf_b;
	word_t alu_b;
	word_t alu_y;
	word_t wd;

	mem_bus_if mbus ();

	instr_decoder u_dec (
		.clk(clk), .RESET(RESET), .ir(ir), .ir_valid(ir_valid),
		.busy(busy), .start(start), .dec(dec)
	);

	control_unit u_ctrl (
		.clk(clk), .RESET(RESET), .start(start), .dec(dec),
		.busy(busy), .done(done), .illegal(illegal),
		.rs_a(rs_a), .rs_b(rs_b), .rd(rd), .rf_we(rf_we), .wb_sel(wb_sel),
		.alu_op(alu_op), .b_imm(b_imm), .imm(imm), .alu_y(alu_y), .mem(mbus.ctrl)
	);

	reg_file u_rf (
		.clk(clk), .RESET(RESET), .ra(rs_a), .rb(rs_b), .a(rf_a), .b(rf_b),
		.wa(rd), .we(rf_we), .wd(wd)
	);

	// Operand B from register or simm13
	assign alu_b = b_imm ? imm : rf_b;

	alu u_alu (.op(alu_op), .a(rf_a), .b(alu_b), .y(alu_y));

	// Write back ALU result or loaded MDR
	assign wd = wb_sel ? mbus.rdata : alu_y;

	mem_port u_mem (
		.clk(clk), .RESET(RESET), .bus(mbus.port),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_size(mem_size),
		.mem_read(mem_read), .mem_write(mem_write), .mem_rdata(mem_rdata), .mfc(mfc)
	);

endmodule

`default_nettype wire

//--- hdl/sparc_pkg.sv
`default_nettype none

package sparc_pkg;

	// Data word and register index
	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_idx_t;

	// Instruction families from op field IR[31:30]
	typedef enum logic [1:0] {
		fam_branch = 2'b00,
		fam_call   = 2'b01,
		fam_arith  = 2'b10,
		fam_mem    = 2'b11
	} family_e;

	// Arithmetic and logic op3 codes
	typedef enum logic [5:0] {
		alu_add  = 6'b000000,
		alu_and  = 6'b000001,
		alu_or   = 6'b000010,
		alu_xor  = 6'b000011,
		alu_sub  = 6'b000100,
		alu_andn = 6'b000101,
		alu_orn  = 6'b000110,
		alu_sll  = 6'b100101,
		alu_srl  = 6'b100110,
		alu_sra  = 6'b100111
	} alu_op_e;

	// Load and store op3 codes, overlap the ALU values
	typedef enum logic [5:0] {
		mem_ld   = 6'b000000,
		mem_ldub = 6'b000001,
		mem_lduh = 6'b000010,
		mem_ldsb = 6'b001001,
		mem_ldsh = 6'b001010,
		mem_st   = 6'b000100,
		mem_stb  = 6'b000101,
		mem_sth  = 6'b000110
	} mem_op_e;

	// Access width on the memory bus
	typedef enum logic [1:0] {
		size_byte = 2'b00,
		size_half = 2'b01,
		size_word = 2'b10
	} mem_size_e;

	// Instruction after field split
	typedef struct packed {
		family_e  family;
		logic [5:0] op3;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		logic     use_imm;
		word_t    imm;
		logic     legal;
	} decoded_t;

endpackage

`default_nettype wire

//--- sparc_core.f
hdl/sparc_pkg.sv
hdl/mem_bus_if.sv
hdl/instr_decoder.sv
hdl/control_unit.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/mem_port.sv
hdl/sparc_core.sv
testbench/core_checker.sv
testbench/tb_sparc_core.sv

//--- testbench/core_checker.sv
`default_nettype none

module core_checker (
	input logic clk,
	input logic RESET,
	input logic [31:0] ir,
	input logic ir_valid,
	input logic busy,
	input logic done,
	input logic illegal,
	input logic [31:0] mem_addr,
	input logic [31:0] mem_wdata,
	input logic [1:0] mem_size,
	input logic mem_read,
	input logic mem_write,
	input logic mfc,
	input int test_id,
	output int checks,
	output int errors
);
	// Longest wait for done on one instruction
	localparam int done_limit = 12;

	logic [31:0] regs [32];
	logic [7:0] ref_mem [1024];
	logic pending;
	logic short_op;
	logic exp_illegal;
	logic is_store;
	logic write_seen;
	logic was_reset;
	int cyc;
	int cur_test;
	int base_checks;
	int base_errors;
	logic [31:0] exp_addr;
	logic [31:0] exp_data;
	logic [31:0] exp_mask;
	logic [1:0] exp_size;

	// Power-up memory contents, mixes all address bits
	function automatic logic [7:0] fill_byte(input int i);
		return 8'((i * 157) ^ (i >> 4));
	endfunction

	function automatic string test_label(input int id);
		case (id)
			0: return "reset";
			1: return "imm_arith";
			2: return "reg_arith";
			3: return "loads";
			4: return "stores";
			5: return "timing_illegal";
			default: return "end";
		endcase
	endfunction

	// Expected result of one arithmetic op3
	function automatic logic [31:0] ref_alu(input logic [5:0] op3, input logic [31:0] a,
		input logic [31:0] b);
		case (op3)
			6'b000000: return a + b;
			6'b000001: return a & b;
			6'b000010: return a | b;
			6'b000011: return a ^ b;
			6'b000100: return a - b;
			6'b000101: return a & ~b;
			6'b000110: return a | ~b;
			6'b100101: return a << b[4:0];
			6'b100110: return a >> b[4:0];
			default: return 32'($signed(a) >>> b[4:0]);
		endcase
	endfunction

	// Big-endian read, extended by size and sign
	function automatic logic [31:0] load_value(input logic [5:0] op3, input logic [31:0] addr);
		int a;
		logic [15:0] h;
		a = int'(addr[9:0]);
		h = {ref_mem[a], ref_mem[a + 1]};
		case (op3)
			6'b000001: return {24'd0, ref_mem[a]};
			6'b001001: return {{24{ref_mem[a][7]}}, ref_mem[a]};
			6'b000010: return {16'd0, h};
			6'b001010: return {{16{h[15]}}, h};
			default: return {h, ref_mem[a + 2], ref_mem[a + 3]};
		endcase
	endfunction

	task automatic report_value(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		$display("MISMATCH %s %s: expected %h, actual %h", test_label(cur_test), what, exp, act);
		errors++;
	endtask

	task automatic report_text(input string msg);
		$display("ERROR %s: %s", test_label(cur_test), msg);
		errors++;
	endtask

	initial begin
		checks = 0;
		errors = 0;
		pending = 1'b0;
		was_reset = 1'b0;
		cur_test = 0;
		base_checks = 0;
		base_errors = 0;
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		for (int i = 0; i < 1024; i++) begin
			ref_mem[i] = fill_byte(i);
		end
	end

	always @(posedge clk) begin
		logic [1:0] fam;
		logic [5:0] op3;
		logic [4:0] rd;
		logic [31:0] a;
		logic [31:0] b;
		int ea;
		// Test boundary, summary of the finished one
		if (test_id != cur_test) begin
			$display("%s: %0d checks, %0d errors", test_label(cur_test),
				checks - base_checks, errors - base_errors);
			base_checks = checks;
			base_errors = errors;
			cur_test = test_id;
		end
		if (RESET) begin
			was_reset = 1'b1;
			pending = 1'b0;
		end else begin
			if (was_reset) begin
				was_reset = 1'b0;
				checks++;
				if ({busy, done, illegal, mem_read, mem_write} !== 5'b0) begin
					report_value("outputs after reset", 32'd0,
						{27'd0, busy, done, illegal, mem_read, mem_write});
				end
			end
			// Memory write completes on this edge
			if (mem_write && mfc) begin
				if (!(pending && is_store) || write_seen) begin
					report_text("memory write with no store pending");
				end else begin
					write_seen = 1'b1;
					checks++;
					if (mem_addr !== exp_addr) begin
						report_value("store address", exp_addr, mem_addr);
					end
					if (mem_size !== exp_size) begin
						report_value("store size", {30'd0, exp_size}, {30'd0, mem_size});
					end
					if ((mem_wdata & exp_mask) !== (exp_data & exp_mask)) begin
						report_value("store data", exp_data & exp_mask, mem_wdata & exp_mask);
					end
				end
			end
			if (pending) begin
				cyc++;
				if (done) begin
					pending = 1'b0;
					checks++;
					if (short_op && cyc != 2) begin
						report_text($sformatf("done came %0d cycles after acceptance, not 2", cyc));
					end
					if (illegal && !exp_illegal) begin
						report_text("illegal raised for a supported instruction");
					end else if (!illegal && exp_illegal) begin
						report_text("illegal missing for an unsupported op3");
					end
					if (is_store && !write_seen) begin
						report_text("store finished without a memory write");
					end
				end else if (cyc > done_limit) begin
					report_text($sformatf("no done within %0d cycles", done_limit));
					pending = 1'b0;
				end
			end else if (done) begin
				report_text("done with no instruction pending");
			end
			// Accepted instruction, update the reference state
			if (ir_valid && !busy) begin
				fam = ir[31:30];
				rd = ir[29:25];
				op3 = ir[24:19];
				a = regs[ir[18:14]];
				b = ir[13] ? {{19{ir[12]}}, ir[12:0]} : regs[ir[4:0]];
				pending = 1'b1;
				cyc = 0;
				short_op = 1'b1;
				exp_illegal = 1'b0;
				is_store = 1'b0;
				write_seen = 1'b0;
				if (fam == 2'b10) begin
					case (op3)
						6'b000000, 6'b000001, 6'b000010, 6'b000011, 6'b000100,
						6'b000101, 6'b000110, 6'b100101, 6'b100110, 6'b100111: begin
							if (rd != 5'd0) begin
								regs[rd] = ref_alu(op3, a, b);
							end
						end
						default: exp_illegal = 1'b1;
					endcase
				end else if (fam == 2'b11) begin
					exp_addr = a + b;
					ea = int'(exp_addr[9:0]);
					exp_data = regs[rd];
					case (op3)
						6'b000000, 6'b000001, 6'b000010, 6'b001001, 6'b001010: begin
							short_op = 1'b0;
							if (rd != 5'd0) begin
								regs[rd] = load_value(op3, exp_addr);
							end
						end
						6'b000100: begin
							short_op = 1'b0;
							is_store = 1'b1;
							exp_size = 2'b10;
							exp_mask = 32'hffff_ffff;
							for (int k = 0; k < 4; k++) begin
								ref_mem[ea + k] = exp_data[31 - 8 * k -: 8];
							end
						end
						6'b000101: begin
							short_op = 1'b0;
							is_store = 1'b1;
							exp_size = 2'b00;
							exp_mask = 32'h0000_00ff;
							ref_mem[ea] = exp_data[7:0];
						end
						6'b000110: begin
							short_op = 1'b0;
							is_store = 1'b1;
							exp_size = 2'b01;
							exp_mask = 32'h0000_ffff;
							ref_mem[ea] = exp_data[15:8];
							ref_mem[ea + 1] = exp_data[7:0];
						end
						default: exp_illegal = 1'b1;
					endcase
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- testbench/tb_sparc_core.sv
`default_nettype none

module tb_sparc_core;

	localparam int period = 100;
	localparam int reset_cycles = 16;
	// Instructions per test 60, 49, 40, 48 and 20
	localparam int instr_count = 217;
	localparam int watchdog_cycles = instr_count * 12 + reset_cycles;

	logic clk;
	logic RESET;
	logic [31:0] ir;
	logic ir_valid;
	logic busy;
	logic done;
	logic illegal;
	logic [31:0] mem_addr;
	logic [31:0] mem_wdata;
	logic [1:0] mem_size;
	logic mem_read;
	logic mem_write;
	logic [31:0] mem_rdata;
	logic mfc;
	int test_id;
	int checks;
	int errors;
	logic [31:0] stim_rng;
	logic [31:0] dly_rng;
	logic [7:0] mem [1024];
	logic sweep_on;
	int sweep_n;

	sparc_core dut (
		.clk(clk), .RESET(RESET), .ir(ir), .ir_valid(ir_valid),
		.busy(busy), .done(done), .illegal(illegal),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_size(mem_size),
		.mem_read(mem_read), .mem_write(mem_write), .mem_rdata(mem_rdata), .mfc(mfc)
	);

	core_checker chk (
		.clk(clk), .RESET(RESET), .ir(ir), .ir_valid(ir_valid), .busy(busy),
		.done(done), .illegal(illegal), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_size(mem_size), .mem_read(mem_read), .mem_write(mem_write), .mfc(mfc),
		.test_id(test_id), .checks(checks), .errors(errors)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		stim_rng = xorshift(stim_rng);
		return stim_rng;
	endfunction

	function automatic logic [7:0] fill_byte(input int i);
		return 8'((i * 157) ^ (i >> 4));
	endfunction

	// Format 3 word of op, rd, op3, rs1, i and simm13 or rs2
	function automatic logic [31:0] encode(input logic [1:0] fam, input logic [5:0] op3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic use_imm, input logic [12:0] low);
		return {fam, rd, op3, rs1, use_imm, low};
	endfunction

	function automatic logic [5:0] alu_code(input int i);
		case (i)
			0: return 6'b000000;
			1: return 6'b000001;
			2: return 6'b000010;
			3: return 6'b000011;
			4: return 6'b000100;
			5: return 6'b000101;
			6: return 6'b000110;
			7: return 6'b100101;
			8: return 6'b100110;
			default: return 6'b100111;
		endcase
	endfunction

	// Random address below 1024 aligned to the access size
	function automatic logic [12:0] rand_addr(input int align);
		logic [31:0] r;
		r = next_rand();
		return {3'd0, r[9:0] & ~10'(align - 1)};
	endfunction

	// Send one instruction and wait for its done
	task automatic issue(input logic [31:0] instr);
		ir <= instr;
		ir_valid <= 1'b1;
		@(posedge clk);
		ir_valid <= 1'b0;
		while (!done) begin
			@(posedge clk);
		end
	endtask

	task automatic set_reg(input logic [4:0] rd, input logic [12:0] v);
		issue(encode(2'b10, 6'b000010, rd, 5'd0, 1'b1, v));
	endtask

	task automatic store_word(input logic [4:0] rd, input logic [12:0] addr);
		issue(encode(2'b11, 6'b000100, rd, 5'd0, 1'b1, addr));
	endtask

	initial begin
		clk = 1'b0;
		forever begin
			#(period / 2) clk = ~clk;
		end
	end

	// Memory model answering each strobe after 0 to 5 cycles
	initial begin
		int a;
		int dly;
		mem_rdata = '0;
		mfc = 1'b0;
		dly_rng = 32'hdbaf_72d3;
		for (int i = 0; i < 1024; i++) begin
			mem[i] = fill_byte(i);
		end
		forever begin
			@(posedge clk);
			if (mem_read || mem_write) begin
				dly_rng = xorshift(dly_rng);
				dly = sweep_on ? sweep_n % 6 : int'(dly_rng % 6);
				sweep_n++;
				repeat (dly) @(posedge clk);
				a = int'(mem_addr[9:0]);
				if (mem_write) begin
					case (mem_size)
						2'b00: mem[a] = mem_wdata[7:0];
						2'b01: begin
							mem[a] = mem_wdata[15:8];
							mem[a + 1] = mem_wdata[7:0];
						end
						default: begin
							for (int k = 0; k < 4; k++) begin
								mem[a + k] = mem_wdata[31 - 8 * k -: 8];
							end
						end
					endcase
				end else begin
					case (mem_size)
						2'b00: mem_rdata <= {24'd0, mem[a]};
						2'b01: mem_rdata <= {16'd0, mem[a], mem[a + 1]};
						default: mem_rdata <= {mem[a], mem[a + 1], mem[a + 2], mem[a + 3]};
					endcase
				end
				mfc <= 1'b1;
				@(posedge clk);
				mfc <= 1'b0;
			end
		end
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("Watchdog expired after %0d cycles, run stopped", watchdog_cycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	// Stimulus
	initial begin
		logic [31:0] r;
		logic [12:0] k;
		logic [12:0] a;
		logic [5:0] op3;
		int align;
		RESET = 1'b1;
		ir = '0;
		ir_valid = 1'b0;
		test_id = 0;
		sweep_on = 1'b0;
		sweep_n = 0;
		stim_rng = 32'hdbaf_72d3;
		repeat (reset_cycles) @(posedge clk);
		RESET <= 1'b0;
		repeat (2) @(posedge clk);

		// Constant into r1 and imm op into r2 before storing r2
		test_id <= 1;
		for (int p = 0; p < 2; p++) begin
			for (int i = 0; i < 10; i++) begin
				r = next_rand();
				k = r[12:0];
				// Second pass starts from negative values
				k[12] = p[0];
				set_reg(5'd1, k);
				r = next_rand();
				issue(encode(2'b10, alu_code(i), 5'd2, 5'd1, 1'b1, r[12:0]));
				store_word(5'd2, rand_addr(4));
			end
		end

		test_id <= 2;
		for (int i = 1; i < 8; i++) begin
			r = next_rand();
			set_reg(5'(i), r[12:0]);
		end
		// Every op twice over random registers
		for (int i = 0; i < 20; i++) begin
			r = next_rand();
			issue(encode(2'b10, alu_code(i % 10), {2'b0, r[6:4]}, {2'b0, r[9:7]}, 1'b0,
				{10'd0, r[12:10]}));
			store_word({2'b0, r[6:4]}, rand_addr(4));
		end
		// Write to r0 must be lost
		issue(encode(2'b10, 6'b000000, 5'd0, 5'd1, 1'b0, 13'd2));
		store_word(5'd0, rand_addr(4));

		test_id <= 3;
		for (int i = 0; i < 5; i++) begin
			case (i)
				0: begin
					op3 = 6'b000000;
					align = 4;
				end
				1: begin
					op3 = 6'b000001;
					align = 1;
				end
				2: begin
					op3 = 6'b000010;
					align = 2;
				end
				3: begin
					op3 = 6'b001001;
					align = 1;
				end
				default: begin
					op3 = 6'b001010;
					align = 2;
				end
			endcase
			for (int j = 0; j < 4; j++) begin
				issue(encode(2'b11, op3, 5'(j + 1), 5'd0, 1'b1, rand_addr(align)));
				store_word(5'(j + 1), rand_addr(4));
			end
		end

		// Store then read the whole word back and store it elsewhere
		test_id <= 4;
		for (int i = 0; i < 3; i++) begin
			op3 = 6'b000100 + 6'(i);
			align = (i == 0) ? 4 : (i == 1) ? 1 : 2;
			for (int j = 0; j < 4; j++) begin
				r = next_rand();
				set_reg(5'd3, r[12:0]);
				a = rand_addr(align);
				issue(encode(2'b11, op3, 5'd3, 5'd0, 1'b1, a));
				issue(encode(2'b11, 6'b000000, 5'd4, 5'd0, 1'b1, a & 13'h1ffc));
				store_word(5'd4, rand_addr(4));
			end
		end

		test_id <= 5;
		sweep_on = 1'b1;
		r = next_rand();
		issue({2'b00, r[29:0]});
		issue({2'b01, r[29:0]});
		// Unsupported op3 codes must leave r5 unchanged
		issue(encode(2'b10, 6'b001000, 5'd5, 5'd1, 1'b1, 13'h7));
		store_word(5'd5, rand_addr(4));
		issue(encode(2'b10, 6'b111111, 5'd5, 5'd1, 1'b1, 13'h7));
		store_word(5'd5, rand_addr(4));
		issue(encode(2'b11, 6'b001101, 5'd5, 5'd1, 1'b1, 13'h7));
		store_word(5'd5, rand_addr(4));
		for (int i = 0; i < 12; i++) begin
			store_word(5'(i % 7 + 1), rand_addr(4));
		end

		test_id <= 6;
		repeat (2) @(posedge clk);
		$display("Totals: %0d checks, %0d errors", checks, errors);
		if (errors == 0 && checks > 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
